/* project.f */
design/cpu_pkg.sv
design/instr_decoder.sv
design/hazard_detection_unit.sv
design/forwarding_unit.sv
design/register_file.sv
design/alu.sv
design/cpu_core.sv
test/cpu_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= cpu_core_tb
FILELIST  ?= project.f

SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv)
SIM     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* test/cpu_core_tb.sv */
module cpu_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int    CLK_PERIOD = 40;
  localparam int    MAX_STEPS  = 10000;   // Reference model step limit
  localparam word_t HLT_WORD   = {OP_HLT, 12'h000};

  logic  clk;
  logic  reset;
  word_t imem_addr, imem_data;
  word_t dmem_addr, dmem_wdata, dmem_rdata;
  logic  dmem_we;
  logic  halted;

  word_t imem     [65536];
  word_t dmem     [65536];
  word_t ref_dmem [65536];  // Reference model's own data memory
  word_t prog [$];          // Program under test
  word_t exp_addr [$];      // Expected store stream
  word_t exp_data [$];
  logic [31:0] lfsr;
  longint deadline_ns;      // Grows with each program

  cpu_core dut_i (
    .clk(clk), .reset(reset),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .dmem_rdata(dmem_rdata),
    .halted(halted)
  );

  //////////////////////////////
  // Clock and memories
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  assign imem_data  = imem[imem_addr];   // Combinational fetch
  assign dmem_rdata = dmem[dmem_addr];

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr] = dmem_wdata;  // Write at the edge
  end

  // Odd multiplier, so every address bit matters
  function automatic word_t fill_word(int addr);
    return word_t'(addr * 40503) ^ 16'h5a3c;
  endfunction

  //////////////////////////////
  // Errors and checks
  //////////////////////////////
  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp));
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp)
      stop_on_error($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  //////////////////////////////
  // LFSR
  //////////////////////////////
  function automatic logic step_lfsr();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h80200003;  // Galois taps
    return b;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(step_lfsr());  // One step per bit
    return v;
  endfunction

  //////////////////////////////
  // Instruction encoders
  //////////////////////////////
  function automatic word_t reg_instr(opcode_e op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};  // ALU, LW and SW share the layout
  endfunction

  function automatic word_t imm_instr(opcode_e op, int rd, int value);
    return {op, 4'(rd), 8'(value)};
  endfunction

  function automatic word_t branch_instr(cond_e c, int off);
    return {OP_B, c, 9'(off)};
  endfunction

  function automatic word_t jump_reg_instr(cond_e c, int rs);
    return {OP_BR, c, 1'b0, 4'(rs), 4'h0};
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic cond_holds(logic [2:0] c, logic fz, logic fn, logic fv);
    case (c)
      3'd0:    return !fz;
      3'd1:    return fz;
      3'd2:    return !fz && !fn;
      3'd3:    return fn;
      3'd4:    return fz || !fn;
      3'd5:    return fn || fz;
      3'd6:    return fv;
      default: return 1'b1;
    endcase
  endfunction

  // Runs prog to HLT, returns steps taken or -1
  function automatic int iss_run();
    word_t r [16];
    word_t pc, ins, a, b, res, addr;
    logic  fz, fn, fv;
    logic [3:0] rd, rs, rt;
    int    steps;
    for (int i = 0; i < 16; i++) r[i] = '0;
    for (int i = 0; i < 65536; i++) ref_dmem[i] = fill_word(i);
    fz = 1'b0;
    fn = 1'b0;
    fv = 1'b0;
    pc = '0;
    steps = 0;
    while (steps < MAX_STEPS) begin
      ins = (int'(pc) < prog.size()) ? prog[pc] : HLT_WORD;
      steps++;
      rd = ins[11:8];
      rs = ins[7:4];
      rt = ins[3:0];
      a  = r[rs];
      b  = r[rt];
      addr = r[rs] + {{12{ins[3]}}, ins[3:0]};
      pc = pc + 16'd1;
      case (ins[15:12])
        4'd0, 4'd1: begin  // ADD, SUB
          res = (ins[12]) ? a - b : a + b;
          fz  = (res == '0);
          fn  = res[15];
          fv  = ins[12] ? ((a[15] != b[15]) && (res[15] != a[15]))
                        : ((a[15] == b[15]) && (res[15] != a[15]));
          if (rd != 0) r[rd] = res;
        end
        4'd2: begin  // XOR touches Z only
          res = a ^ b;
          fz  = (res == '0);
          if (rd != 0) r[rd] = res;
        end
        4'd8: if (rd != 0) r[rd] = ref_dmem[addr];
        4'd9: begin
          ref_dmem[addr] = r[rd];
          exp_addr.push_back(addr);
          exp_data.push_back(r[rd]);
        end
        4'd10: if (rd != 0) r[rd] = {r[rd][15:8], ins[7:0]};
        4'd11: if (rd != 0) r[rd] = {ins[7:0], r[rd][7:0]};
        4'd12: if (cond_holds(ins[11:9], fz, fn, fv)) pc = pc + {{7{ins[8]}}, ins[8:0]};
        4'd13: if (cond_holds(ins[11:9], fz, fn, fv)) pc = r[rs];
        4'd15: return steps;
        default: ;  // No-op
      endcase
    end
    return -1;
  endfunction

  //////////////////////////////
  // Compare and watchdog
  //////////////////////////////
  always @(negedge clk) begin  // Outputs settled mid-cycle
    if (!reset && dmem_we) begin
      if (halted) stop_on_error("A store appeared after the core halted");
      if (exp_addr.size() == 0) stop_on_error("The core issued a store the reference never made");
      check_word("dmem_addr", dmem_addr, exp_addr.pop_front());
      check_word("dmem_wdata", dmem_wdata, exp_data.pop_front());
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      if ($time > deadline_ns) stop_on_error("Time limit reached before halted rose");
    end
  end

  //////////////////////////////
  // Program runner
  //////////////////////////////
  task automatic run_program();
    int n;
    for (int i = 0; i < 65536; i++) begin  // Core is idle or halted here
      imem[i] = (i < prog.size()) ? prog[i] : HLT_WORD;
      dmem[i] = fill_word(i);
    end
    exp_addr.delete();
    exp_data.delete();
    n = iss_run();
    if (n < 0) stop_on_error("Reference model never reached HLT");
    deadline_ns = deadline_ns + longint'((8 * n + 50) * CLK_PERIOD);
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (8) @(posedge clk);
    #2 reset = 1'b0;
    while (!halted) @(negedge clk);
    repeat (4) @(negedge clk);  // Catch late stores
    check_count("stores_left", exp_addr.size(), 0);
    prog.delete();
  endtask

  // Random body around two fixed base registers
  task automatic build_random(int len);
    int kind, rd, last;
    opcode_e op;
    last = len + 2;  // HLT index
    prog.push_back(imm_instr(OP_LLB, 14, 8'h10));
    prog.push_back(imm_instr(OP_LLB, 15, 8'h30));
    for (int i = 2; i < last; i++) begin
      kind = rand_bits(3);
      rd   = rand_bits(4) % 14;  // r14 and r15 stay bases
      case (kind)
        0, 1, 2, 7: begin
          op = (kind == 0) ? OP_ADD : (kind == 1) ? OP_SUB : OP_XOR;
          prog.push_back(reg_instr(op, rd, rand_bits(4), rand_bits(4)));
        end
        3: prog.push_back(imm_instr(rand_bits(1) ? OP_LHB : OP_LLB, rd, rand_bits(8)));
        4: prog.push_back(reg_instr(OP_LW, rd, 14 + rand_bits(1), rand_bits(4)));
        5: prog.push_back(reg_instr(OP_SW, rand_bits(4), 14 + rand_bits(1), rand_bits(4)));
        default: begin
          rd = 1 + rand_bits(2);  // Forward offset
          if (i + 1 + rd > last) rd = last - i - 1;
          prog.push_back(branch_instr(cond_e'(3'(rand_bits(3))), rd));
        end
      endcase
    end
    prog.push_back(HLT_WORD);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    reset       = 1'b1;
    lfsr        = 32'h6abf4580;
    deadline_ns = 0;

    // Dependent ALU chain with stores
    prog.push_back(imm_instr(OP_LLB, 1, 8'h34));
    prog.push_back(imm_instr(OP_LHB, 1, 8'h12));
    prog.push_back(imm_instr(OP_LLB, 2, 8'hff));
    prog.push_back(imm_instr(OP_LHB, 2, 8'h7f));
    prog.push_back(reg_instr(OP_ADD, 3, 1, 2));  // EX->EX
    prog.push_back(reg_instr(OP_SUB, 4, 3, 1));
    prog.push_back(reg_instr(OP_XOR, 5, 4, 3));  // MEM->EX on rt
    prog.push_back(reg_instr(OP_ADD, 6, 5, 5));
    prog.push_back(imm_instr(OP_LLB, 15, 8'h40));
    prog.push_back(reg_instr(OP_SW, 3, 15, 0));
    prog.push_back(reg_instr(OP_SW, 4, 15, 1));
    prog.push_back(reg_instr(OP_SW, 5, 15, 2));
    prog.push_back(reg_instr(OP_SW, 6, 15, 3));
    prog.push_back(reg_instr(OP_ADD, 7, 1, 1));
    prog.push_back(reg_instr(OP_SW, 7, 15, 4));  // Store data straight from EX
    prog.push_back(HLT_WORD);
    run_program();

    // Load-to-use and load-then-store
    prog.push_back(imm_instr(OP_LLB, 15, 8'h10));
    prog.push_back(reg_instr(OP_LW, 1, 15, 0));
    prog.push_back(reg_instr(OP_ADD, 2, 1, 1));  // One-cycle stall
    prog.push_back(reg_instr(OP_SW, 2, 15, 1));
    prog.push_back(reg_instr(OP_LW, 3, 15, 2));
    prog.push_back(reg_instr(OP_SW, 3, 15, 3));  // MEM->MEM bypass
    prog.push_back(reg_instr(OP_LW, 4, 15, -4));
    prog.push_back(reg_instr(OP_XOR, 5, 2, 4));
    prog.push_back(reg_instr(OP_SW, 4, 15, -1));
    prog.push_back(reg_instr(OP_SW, 5, 15, 5));
    prog.push_back(HLT_WORD);
    run_program();

    // Every condition against four flag setups
    prog.push_back(imm_instr(OP_LLB, 1, 5));
    prog.push_back(imm_instr(OP_LLB, 2, 3));
    prog.push_back(imm_instr(OP_LLB, 4, 8'hff));
    prog.push_back(imm_instr(OP_LHB, 4, 8'h7f));
    prog.push_back(imm_instr(OP_LLB, 7, 1));
    prog.push_back(imm_instr(OP_LHB, 15, 1));
    for (int c = 0; c < 8; c++) begin
      for (int s = 0; s < 4; s++) begin
        prog.push_back(reg_instr(OP_ADD, 15, 15, 7));  // Fresh address per case
        case (s)
          0:       prog.push_back(reg_instr(OP_SUB, 3, 1, 1));  // Z
          1:       prog.push_back(reg_instr(OP_SUB, 3, 2, 1));  // N
          2:       prog.push_back(reg_instr(OP_SUB, 3, 1, 2));  // All clear
          default: prog.push_back(reg_instr(OP_ADD, 3, 4, 4));  // N and V
        endcase
        prog.push_back(branch_instr(cond_e'(3'(c)), 1));
        prog.push_back(reg_instr(OP_SW, 3, 15, 0));  // Only when not taken
        prog.push_back(reg_instr(OP_SW, 1, 15, 1));
      end
    end
    prog.push_back(HLT_WORD);
    run_program();

    // BR through fresh registers
    prog.push_back(imm_instr(OP_LLB, 15, 8'h20));
    prog.push_back(imm_instr(OP_LLB, 2, 8'h11));
    prog.push_back(imm_instr(OP_LLB, 1, 6));
    prog.push_back(jump_reg_instr(COND_AL, 1));  // Target written one before
    prog.push_back(reg_instr(OP_SW, 2, 15, 0));
    prog.push_back(reg_instr(OP_SW, 2, 15, 1));
    prog.push_back(reg_instr(OP_SW, 15, 15, 2));
    prog.push_back(imm_instr(OP_LLB, 1, 12));
    prog.push_back(imm_instr(OP_LLB, 3, 8'h55));
    prog.push_back(jump_reg_instr(COND_AL, 1));  // Target written two before
    prog.push_back(reg_instr(OP_SW, 2, 15, 3));
    prog.push_back(reg_instr(OP_SW, 2, 15, 4));
    prog.push_back(reg_instr(OP_SW, 3, 15, 5));
    prog.push_back(HLT_WORD);
    run_program();

    for (int p = 0; p < 20; p++) begin
      build_random(30);
      run_program();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

/* design/cpu_core.sv */
module cpu_core (
  input  logic           clk,
  input  logic           reset,
  output cpu_pkg::word_t imem_addr,
  input  cpu_pkg::word_t imem_data,
  output cpu_pkg::word_t dmem_addr,
  output cpu_pkg::word_t dmem_wdata,
  output logic           dmem_we,
  input  cpu_pkg::word_t dmem_rdata,
  output logic           halted
);
  import cpu_pkg::*;

  // Fetch
  word_t pc, pc_plus1;
  logic  fetch_stop;                  // Sticky once HLT leaves decode
  word_t if_id_instr, if_id_pc1;

  // Decode
  reg_addr_t id_rs, id_rt, id_rd;
  alu_op_e   id_alu_op;
  word_t     id_imm, id_rdata1, id_rdata2, branch_target;
  logic      id_use_imm, id_reg_write, id_mem_enable, id_mem_write;
  logic      id_set_zn, id_set_v, id_branch, id_branch_reg, branch_taken, id_halt;
  logic      pc_stall, if_id_stall, id_flush, if_flush;
  logic      flag_z, flag_n, flag_v;

  // Execute
  reg_addr_t ex_rs, ex_rt, ex_rd;
  alu_op_e   ex_alu_op;
  word_t     ex_rdata1, ex_rdata2, ex_imm, ex_a, ex_b_reg, ex_result;
  logic      ex_use_imm, ex_reg_write, ex_mem_enable, ex_mem_write;
  logic      ex_set_zn, ex_set_v, ex_halt, alu_z, alu_n, alu_v;
  logic [1:0] fwd_a, fwd_b;

  // Memory and write-back
  reg_addr_t mem_rd, mem_rt, wb_rd;
  word_t     mem_result, mem_store_data, wb_data;
  logic      mem_reg_write, mem_mem_enable, mem_mem_write, mem_halt;
  logic      wb_reg_write, wb_halt, halt_q, fwd_store;

  ////////////////////////////////
  // Fetch
  ////////////////////////////////
  assign imem_addr = pc;
  assign pc_plus1  = pc + 16'd1;
  assign branch_target = id_branch_reg ? id_rdata1 : (if_id_pc1 + id_imm);  // BR uses rs value

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= RESET_PC;
      fetch_stop <= 1'b0;
    end else begin
      fetch_stop <= fetch_stop | id_halt;
      if (pc_stall || id_halt || fetch_stop) pc <= pc;  // Frozen
      else if (branch_taken) pc <= branch_target;
      else pc <= pc_plus1;                               // Predict not taken
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_instr <= NOP_WORD;
      if_id_pc1   <= RESET_PC;
    end else if (id_halt || fetch_stop) begin
      if_id_instr <= NOP_WORD;  // Only no-ops decode after HLT
    end else if (!if_id_stall) begin
      if_id_instr <= if_flush ? NOP_WORD : imem_data;
      if_id_pc1   <= pc_plus1;
    end
  end

  ////////////////////////////////
  // Decode
  ////////////////////////////////
  instr_decoder u_decoder (
    .instr(if_id_instr), .flag_z(flag_z), .flag_n(flag_n), .flag_v(flag_v),
    .rs(id_rs), .rt(id_rt), .rd(id_rd), .alu_op(id_alu_op),
    .use_imm(id_use_imm), .imm(id_imm), .reg_write(id_reg_write),
    .mem_enable(id_mem_enable), .mem_write(id_mem_write),
    .set_flags_zn(id_set_zn), .set_flags_v(id_set_v),
    .branch(id_branch), .branch_reg(id_branch_reg),
    .branch_taken(branch_taken), .halt(id_halt)
  );

  register_file u_regs (
    .clk(clk), .reset(reset),
    .raddr1(id_rs), .raddr2(id_rt), .rdata1(id_rdata1), .rdata2(id_rdata2),
    .waddr(wb_rd), .wdata(wb_data), .we(wb_reg_write)
  );

  hazard_detection_unit u_hazard (
    .id_rs(id_rs), .id_rt(id_rt), .id_mem_write(id_mem_write),
    .id_branch(id_branch), .id_branch_reg(id_branch_reg), .branch_taken(branch_taken),
    .ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_mem_enable(ex_mem_enable),
    .ex_mem_write(ex_mem_write), .ex_set_flags(ex_set_zn | ex_set_v),
    .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
    .pc_stall(pc_stall), .if_id_stall(if_id_stall), .id_flush(id_flush), .if_flush(if_flush)
  );

  // ID/EX, controls cleared on a bubble
  always_ff @(posedge clk) begin
    if (reset || id_flush) begin
      ex_reg_write  <= 1'b0;
      ex_mem_enable <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_set_zn     <= 1'b0;
      ex_set_v      <= 1'b0;
      ex_halt       <= 1'b0;
      ex_use_imm    <= 1'b0;
      ex_alu_op     <= ALU_PASS;
    end else begin
      ex_reg_write  <= id_reg_write;
      ex_mem_enable <= id_mem_enable;
      ex_mem_write  <= id_mem_write;
      ex_set_zn     <= id_set_zn;
      ex_set_v      <= id_set_v;
      ex_halt       <= id_halt;
      ex_use_imm    <= id_use_imm;
      ex_alu_op     <= id_alu_op;
    end
  end

  always_ff @(posedge clk) begin  // Payload
    ex_rs     <= id_rs;
    ex_rt     <= id_rt;
    ex_rd     <= id_rd;
    ex_rdata1 <= id_rdata1;
    ex_rdata2 <= id_rdata2;
    ex_imm    <= id_imm;
  end

  ////////////////////////////////
  // Execute
  ////////////////////////////////
  forwarding_unit u_fwd (
    .ex_rs(ex_rs), .ex_rt(ex_rt),
    .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
    .mem_mem_enable(mem_mem_enable), .mem_mem_write(mem_mem_write),
    .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .mem_store_rd(mem_rt),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store)
  );

  assign ex_a     = (fwd_a == FWD_MEM) ? mem_result : (fwd_a == FWD_WB) ? wb_data : ex_rdata1;
  assign ex_b_reg = (fwd_b == FWD_MEM) ? mem_result : (fwd_b == FWD_WB) ? wb_data : ex_rdata2;

  alu u_alu (
    .a(ex_a), .b(ex_use_imm ? ex_imm : ex_b_reg), .op(ex_alu_op),
    .result(ex_result), .z(alu_z), .n(alu_n), .v(alu_v)
  );

  // Flags written at the end of execute
  always_ff @(posedge clk) begin
    if (reset) begin
      flag_z <= 1'b0;
      flag_n <= 1'b0;
      flag_v <= 1'b0;
    end else begin
      if (ex_set_zn) flag_z <= alu_z;
      if (ex_set_v) begin  // add/sub only
        flag_n <= alu_n;
        flag_v <= alu_v;
      end
    end
  end

  // EX/MEM
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write  <= 1'b0;
      mem_mem_enable <= 1'b0;
      mem_mem_write  <= 1'b0;
      mem_halt       <= 1'b0;
    end else begin
      mem_reg_write  <= ex_reg_write;
      mem_mem_enable <= ex_mem_enable;
      mem_mem_write  <= ex_mem_write;
      mem_halt       <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_result     <= ex_result;
    mem_store_data <= ex_b_reg;  // Store data after bypass
    mem_rd         <= ex_rd;
    mem_rt         <= ex_rt;
  end

  ////////////////////////////////
  // Memory and write-back
  ////////////////////////////////
  assign dmem_addr  = mem_result;
  assign dmem_wdata = fwd_store ? wb_data : mem_store_data;
  assign dmem_we    = mem_mem_enable & mem_mem_write;  // One pulse per SW

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      wb_halt      <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
      wb_halt      <= mem_halt;
      halt_q       <= halt_q | wb_halt;  // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= (mem_mem_enable && !mem_mem_write) ? dmem_rdata : mem_result;
    wb_rd   <= mem_rd;
  end

  assign halted = halt_q | wb_halt;

endmodule

/* design/alu.sv */
module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_e op,
  output cpu_pkg::word_t   result,
  output logic             z,
  output logic             n,
  output logic             v
);
  import cpu_pkg::*;

  word_t sum;
  word_t diff;
  logic  add_ovf;  // Signed overflow of a + b
  logic  sub_ovf;  // Signed overflow of a - b

  assign sum  = a + b;  // Wraps
  assign diff = a - b;

  // Same-sign operands, different-sign result
  assign add_ovf = (a[15] == b[15]) & (sum[15] != a[15]);
  // Operand signs differ and result flips from a
  assign sub_ovf = (a[15] != b[15]) & (diff[15] != a[15]);

  always_comb begin
    case (op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_XOR: result = a ^ b;
      ALU_LLB: result = {a[15:8], b[7:0]};  // Replace low byte
      ALU_LHB: result = {b[7:0], a[7:0]};   // Replace high byte
      default: result = b;                  // PASS
    endcase
  end

  assign z = (result == '0);
  assign n = result[15];

  always_comb begin
    case (op)
      ALU_ADD: v = add_ovf;
      ALU_SUB: v = sub_ovf;
      default: v = 1'b0;
    endcase
  end

endmodule

/* design/register_file.sv */
module register_file (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::reg_addr_t raddr1,
  input  cpu_pkg::reg_addr_t raddr2,
  output cpu_pkg::word_t     rdata1,
  output cpu_pkg::word_t     rdata2,
  input  cpu_pkg::reg_addr_t waddr,
  input  cpu_pkg::word_t     wdata,
  input  logic               we
);
  import cpu_pkg::*;

  word_t regs [NUM_REGS];
  logic  wr_live;  // Write that actually lands

  assign wr_live = we & (waddr != '0);  // r0 is fixed at zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (wr_live) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through covers write-back -> decode
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (wr_live && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (wr_live && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* design/forwarding_unit.sv */
module forwarding_unit (
  input  cpu_pkg::reg_addr_t ex_rs,
  input  cpu_pkg::reg_addr_t ex_rt,
  input  cpu_pkg::reg_addr_t mem_rd,
  input  logic               mem_reg_write,
  input  logic               mem_mem_enable,
  input  logic               mem_mem_write,
  input  cpu_pkg::reg_addr_t wb_rd,
  input  logic               wb_reg_write,
  input  cpu_pkg::reg_addr_t mem_store_rd,
  output logic [1:0]         fwd_a,
  output logic [1:0]         fwd_b,
  output logic               fwd_store
);
  import cpu_pkg::*;

  logic mem_src_ok;  // Memory stage holds a ready ALU result
  logic wb_src_ok;   // Write-back holds a real register write

  // A load in memory has no data yet
  assign mem_src_ok = mem_reg_write & ~(mem_mem_enable & ~mem_mem_write) & (mem_rd != '0);
  assign wb_src_ok  = wb_reg_write & (wb_rd != '0);

  // Youngest producer wins
  always_comb begin
    fwd_a = FWD_NONE;
    if (mem_src_ok && mem_rd == ex_rs) fwd_a = FWD_MEM;
    else if (wb_src_ok && wb_rd == ex_rs) fwd_a = FWD_WB;
  end

  always_comb begin
    fwd_b = FWD_NONE;
    if (mem_src_ok && mem_rd == ex_rt) fwd_b = FWD_MEM;
    else if (wb_src_ok && wb_rd == ex_rt) fwd_b = FWD_WB;
  end

  // Store data from a load one stage ahead
  assign fwd_store = mem_mem_enable & mem_mem_write & wb_src_ok & (wb_rd == mem_store_rd);

endmodule

/* design/hazard_detection_unit.sv */
module hazard_detection_unit (
  input  cpu_pkg::reg_addr_t id_rs,
  input  cpu_pkg::reg_addr_t id_rt,
  input  logic               id_mem_write,
  input  logic               id_branch,
  input  logic               id_branch_reg,
  input  logic               branch_taken,
  input  cpu_pkg::reg_addr_t ex_rd,
  input  logic               ex_reg_write,
  input  logic               ex_mem_enable,
  input  logic               ex_mem_write,
  input  logic               ex_set_flags,
  input  cpu_pkg::reg_addr_t mem_rd,
  input  logic               mem_reg_write,
  output logic               pc_stall,
  output logic               if_id_stall,
  output logic               id_flush,
  output logic               if_flush
);
  import cpu_pkg::*;

  logic ex_load;         // LW sits in execute
  logic load_use;        // Decode needs the load result next cycle
  logic flag_wait;       // Branch waits on flags still being computed
  logic br_ex_match;     // BR target written by execute
  logic br_mem_match;    // BR target written by memory
  logic reg_wait;        // BR waits on its target register
  logic any_stall;

  //////////////////////////////
  // Load-to-use
  //////////////////////////////
  assign ex_load = ex_mem_enable & ~ex_mem_write;

  // rt of a store is skipped, memory->memory bypass covers it
  assign load_use = ex_load & (ex_rd != '0) &
                    ((ex_rd == id_rs) | ((ex_rd == id_rt) & ~id_mem_write));

  //////////////////////////////
  // Branches
  //////////////////////////////
  // Flags land at the end of execute, so one cycle is enough
  assign flag_wait = (id_branch | id_branch_reg) & ex_set_flags;

  assign br_ex_match  = ex_reg_write  & (ex_rd  != '0) & (ex_rd  == id_rs);
  assign br_mem_match = mem_reg_write & (mem_rd != '0) & (mem_rd == id_rs);
  assign reg_wait     = id_branch_reg & (br_ex_match | br_mem_match);  // At most two cycles

  assign any_stall = load_use | flag_wait | reg_wait;

  assign pc_stall    = any_stall;
  assign if_id_stall = any_stall;
  assign id_flush    = load_use;                    // Bubble into execute
  assign if_flush    = branch_taken & ~any_stall;   // Drop the wrong-path fetch

endmodule

/* design/instr_decoder.sv */
module instr_decoder (
  input  cpu_pkg::word_t     instr,
  input  logic               flag_z,
  input  logic               flag_n,
  input  logic               flag_v,
  output cpu_pkg::reg_addr_t rs,
  output cpu_pkg::reg_addr_t rt,
  output cpu_pkg::reg_addr_t rd,
  output cpu_pkg::alu_op_e   alu_op,
  output logic               use_imm,
  output cpu_pkg::word_t     imm,
  output logic               reg_write,
  output logic               mem_enable,
  output logic               mem_write,
  output logic               set_flags_zn,
  output logic               set_flags_v,
  output logic               branch,
  output logic               branch_reg,
  output logic               branch_taken,
  output logic               halt
);
  import cpu_pkg::*;

  opcode_e opcode;
  cond_e   cond;
  logic    cond_true;  // Condition holds for current flags

  assign opcode = opcode_e'(instr[15:12]);
  assign cond   = cond_e'(instr[11:9]);

  // Condition test against the flag register
  always_comb begin
    case (cond)
      COND_NE: cond_true = ~flag_z;
      COND_EQ: cond_true = flag_z;
      COND_GT: cond_true = ~flag_z & ~flag_n;
      COND_LT: cond_true = flag_n;
      COND_GE: cond_true = flag_z | ~flag_n;
      COND_LE: cond_true = flag_n | flag_z;
      COND_OV: cond_true = flag_v;
      default: cond_true = 1'b1;  // AL
    endcase
  end

  always_comb begin
    rs           = '0;  // Unused fields read r0, so no false hazards
    rt           = '0;
    rd           = '0;
    alu_op       = ALU_PASS;
    use_imm      = 1'b0;
    imm          = '0;
    reg_write    = 1'b0;
    mem_enable   = 1'b0;
    mem_write    = 1'b0;
    set_flags_zn = 1'b0;
    set_flags_v  = 1'b0;
    branch       = 1'b0;
    branch_reg   = 1'b0;
    halt         = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_XOR: begin
        rd           = instr[11:8];
        rs           = instr[7:4];
        rt           = instr[3:0];
        reg_write    = 1'b1;
        set_flags_zn = 1'b1;             // Z for all three
        set_flags_v  = (opcode != OP_XOR); // N and V for add/sub only
        alu_op       = (opcode == OP_ADD) ? ALU_ADD :
                       (opcode == OP_SUB) ? ALU_SUB : ALU_XOR;
      end
      OP_LW, OP_SW: begin
        rs         = instr[7:4];                    // Base
        imm        = {{12{instr[3]}}, instr[3:0]};  // Signed word offset
        use_imm    = 1'b1;
        alu_op     = ALU_ADD;
        mem_enable = 1'b1;
        if (opcode == OP_SW) begin
          rt        = instr[11:8];  // Store data register
          mem_write = 1'b1;
        end else begin
          rd        = instr[11:8];
          reg_write = 1'b1;
        end
      end
      OP_LLB, OP_LHB: begin
        rd        = instr[11:8];
        rs        = instr[11:8];  // Old value for the byte merge
        imm       = {8'h00, instr[7:0]};
        use_imm   = 1'b1;
        reg_write = 1'b1;
        alu_op    = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
      end
      OP_B: begin
        imm    = {{7{instr[8]}}, instr[8:0]};  // Added to PC+1
        branch = 1'b1;
      end
      OP_BR: begin
        rs         = instr[7:4];  // Target register
        branch_reg = 1'b1;
      end
      OP_HLT:  halt = 1'b1;
      default: ;  // No-op
    endcase
  end

  assign branch_taken = (branch | branch_reg) & cond_true;

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

  //////////////////////////////
  // Basic word types
  //////////////////////////////
  typedef logic [15:0] word_t;      // Data, instruction or word address
  typedef logic [3:0]  reg_addr_t;  // Register number

  //////////////////////////////
  // Instruction encodings
  //////////////////////////////
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_XOR = 4'd2,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_LHB = 4'd11,
    OP_B   = 4'd12,
    OP_BR  = 4'd13,
    OP_HLT = 4'd15
  } opcode_e;  // Unlisted codes decode as a no-op

  // Branch conditions, held in bits 11:9
  typedef enum logic [2:0] {
    COND_NE = 3'd0,  // Z clear
    COND_EQ = 3'd1,  // Z set
    COND_GT = 3'd2,  // Z and N clear
    COND_LT = 3'd3,  // N set
    COND_GE = 3'd4,  // Z set or N clear
    COND_LE = 3'd5,  // N set or Z set
    COND_OV = 3'd6,  // V set
    COND_AL = 3'd7   // Always
  } cond_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_LLB,
    ALU_LHB,
    ALU_PASS
  } alu_op_e;

  //////////////////////////////
  // Core constants
  //////////////////////////////
  localparam int    NUM_REGS = 16;
  localparam word_t NOP_WORD = 16'h3000;  // Opcode 3, no writes of any kind
  localparam word_t RESET_PC = 16'h0000;

  // Operand bypass selects
  localparam logic [1:0] FWD_NONE = 2'b00;  // Register file value
  localparam logic [1:0] FWD_WB   = 2'b01;  // Write-back data
  localparam logic [1:0] FWD_MEM  = 2'b10;  // Memory-stage ALU result

endpackage
